// ==== verilog/shell_pkg.sv ====
`default_nettype none

package shell_pkg;

	// menu option word, bit positions match the OSD config string
	typedef struct packed {
		logic [2:0]  voffs;     // 31:29 analog video v-pos
		logic [4:0]  hoffs;     // 28:24 analog video h-pos
		logic [14:0] rsv_23_9;
		logic        excite;    // 8, double cpu clock in the core
		logic        rsv_7;
		logic        service;   // 6
		logic [2:0]  rsv_5_3;   // scanlines and blend, used by the scan doubler
		logic        rotate;    // 2
		logic        rsv_1;
		logic        reset_req; // 0, menu reset entry
	} status_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic coin;
		logic one_player;
		logic two_players;
	} buttons_t;

	// both bytes are active low as the core expects them
	typedef struct packed {
		logic [7:0] ctr1;
		logic [7:0] ctr2;
	} ctrl_t;

	typedef struct packed {
		logic        cpu_req;  // flips once per cpu region write
		logic        gfx_req;  // flips once per gfx region write
		logic [22:0] addr;     // word address inside the region
		logic [1:0]  ds;       // {odd, even} byte lane
		logic [15:0] data;
		logic [1:0]  index;
	} rom_wr_t;

	// ps/2 set 2 make codes
	localparam logic [7:0] KEY_UP    = 8'h75;
	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_LEFT  = 8'h6B;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_ESC   = 8'h76; // coin
	localparam logic [7:0] KEY_F1    = 8'h05;
	localparam logic [7:0] KEY_F2    = 8'h06;
	localparam logic [7:0] KEY_ALT   = 8'h11; // fire2
	localparam logic [7:0] KEY_SPACE = 8'h29; // fire1

endpackage

`default_nettype wire

// ==== verilog/video_pkg.sv ====
`default_nettype none

package video_pkg;

	// 4 bits per gun, same order as the core's pixel word
	typedef struct packed {
		logic [3:0] b;
		logic [3:0] g;
		logic [3:0] r;
	} rgb_t;

	typedef struct packed {
		logic [8:0] h;
		logic [8:0] v;
	} raster_t;

	// all active high
	typedef struct packed {
		logic hs;
		logic vs;
		logic hb;
		logic vb;
	} sync_t;

endpackage

`default_nettype wire

// ==== verilog/key_decoder.sv ====
`default_nettype none

module key_decoder (
	input  wire                  CLOCK_48,
	input  wire                  rst,
	input  wire                  key_strobe,
	input  wire                  key_pressed,
	input  wire            [7:0] key_code,
	output shell_pkg::buttons_t  buttons
);

	// each strobe carries one make or break, only the matching button moves
	always_ff @(posedge CLOCK_48) begin
		if (rst) begin
			buttons <= '0;
		end else if (key_strobe) begin
			case (key_code)
				shell_pkg::KEY_UP: begin
					buttons.up <= key_pressed;
				end
				shell_pkg::KEY_DOWN: begin
					buttons.down <= key_pressed;
				end
				shell_pkg::KEY_LEFT: begin
					buttons.left <= key_pressed;
				end
				shell_pkg::KEY_RIGHT: begin
					buttons.right <= key_pressed;
				end
				shell_pkg::KEY_ESC: begin
					buttons.coin <= key_pressed;
				end
				shell_pkg::KEY_F1: begin
					buttons.one_player <= key_pressed;
				end
				shell_pkg::KEY_F2: begin
					buttons.two_players <= key_pressed;
				end
				shell_pkg::KEY_ALT: begin
					buttons.fire2 <= key_pressed;
				end
				shell_pkg::KEY_SPACE: begin
					buttons.fire1 <= key_pressed;
				end
				default: begin
					buttons <= buttons; // unmapped key
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/rom_loader.sv ====
`default_nettype none

module rom_loader #(
	parameter logic [24:0] GFX_BASE = 25'h10000
) (
	input  wire                 CLOCK_48,
	input  wire                 rst,
	input  wire                 ioctl_download,
	input  wire           [7:0] ioctl_index,
	input  wire                 ioctl_wr,
	input  wire          [24:0] ioctl_addr,
	input  wire           [7:0] ioctl_dout,
	input  shell_pkg::status_t  status,
	input  wire                 menu_reset_button,
	output shell_pkg::rom_wr_t  rom_wr,
	output logic                rom_loaded,
	output logic                core_reset
);

	logic        wr_last;
	logic        dl_last;
	logic        wr_rise;
	logic        is_gfx;
	logic [24:0] gfx_addr;
	logic [24:0] wr_addr;

	assign wr_rise  = ioctl_download & ioctl_wr & ~wr_last;
	assign is_gfx   = (ioctl_addr >= GFX_BASE);
	assign gfx_addr = ioctl_addr - GFX_BASE; // offset inside gfx region
	assign wr_addr  = is_gfx ? gfx_addr : ioctl_addr;

	always_ff @(posedge CLOCK_48) begin
		if (rst) begin
			wr_last <= 1'b0;
			dl_last <= 1'b0;
		end else begin
			wr_last <= ioctl_wr;
			dl_last <= ioctl_download;
		end
	end

	// toggle handshake towards the sdram ports, one flip per byte
	always_ff @(posedge CLOCK_48) begin
		if (rst) begin
			rom_wr.cpu_req <= 1'b0;
			rom_wr.gfx_req <= 1'b0;
		end else if (wr_rise) begin
			if (is_gfx) begin
				rom_wr.gfx_req <= ~rom_wr.gfx_req;
			end else begin
				rom_wr.cpu_req <= ~rom_wr.cpu_req;
			end
			rom_wr.addr  <= wr_addr[23:1];
			rom_wr.ds    <= {wr_addr[0], ~wr_addr[0]};
			rom_wr.data  <= {ioctl_dout, ioctl_dout}; // same byte on both lanes
			rom_wr.index <= ioctl_index[1:0];
		end
	end

	// core stays in reset until the first download has ended
	always_ff @(posedge CLOCK_48) begin
		if (rst) begin
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			if (dl_last && !ioctl_download) begin
				rom_loaded <= 1'b1;
			end
			core_reset <= status.reset_req | menu_reset_button | ~rom_loaded;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/control_mapper.sv ====
`default_nettype none

module control_mapper (
	input  wire                  CLOCK_48,
	input  wire                  rst,
	input  shell_pkg::buttons_t  buttons,
	input  wire            [7:0] joystick_0,
	input  wire            [7:0] joystick_1,
	input  shell_pkg::status_t   status,
	output shell_pkg::ctrl_t     ctrl
);

	// idle value, only the inverted coin bit is low
	localparam logic [7:0] CTR1_IDLE = 8'hFF;
	localparam logic [7:0] CTR2_IDLE = 8'h7F;

	logic m_left;
	logic m_right;
	logic m_fire;

	// joystick bits are {.., fire, up, down, left, right}
	always_comb begin
		if (status.rotate) begin
			m_left  = buttons.down | joystick_0[2] | joystick_1[2];
			m_right = buttons.up | joystick_0[3] | joystick_1[3];
		end else begin
			m_left  = buttons.left | joystick_0[1] | joystick_1[1];
			m_right = buttons.right | joystick_0[0] | joystick_1[0];
		end
		m_fire = buttons.fire1 | joystick_0[4] | joystick_1[4];
	end

	always_ff @(posedge CLOCK_48) begin
		if (rst) begin
			ctrl.ctr1 <= CTR1_IDLE;
			ctrl.ctr2 <= CTR2_IDLE;
		end else begin
			ctrl.ctr1 <= ~{1'b0, status.service, buttons.one_player, 2'b00,
				m_fire, m_right, m_left};
			ctrl.ctr2 <= ~{~buttons.coin, 1'b0, buttons.two_players, 2'b00,
				m_fire, m_right, m_left};
		end
	end

endmodule

`default_nettype wire

// ==== verilog/video_timing.sv ====
`default_nettype none

module video_timing #(
	parameter int H_ACTIVE = 256,
	parameter int H_TOTAL  = 384,
	parameter int V_ACTIVE = 224,
	parameter int V_TOTAL  = 264,
	parameter int CE_DIV   = 8,
	parameter int SYNC_LEN = 32
) (
	input  wire                 CLOCK_48,
	input  wire                 rst,
	input  shell_pkg::status_t  status,
	input  video_pkg::rgb_t     core_rgb,
	output logic                pixel_ce,
	output video_pkg::raster_t  raster,
	output video_pkg::sync_t    sync,
	output video_pkg::rgb_t     video_rgb
);

	localparam int CW = (CE_DIV > 1) ? $clog2(CE_DIV) : 1;

	logic [CW-1:0] ce_cnt;
	logic          h_last;
	logic          v_last;
	logic          hblank;
	logic          vblank;
	logic [9:0]    hs_start;
	logic [9:0]    vs_start;
	logic [9:0]    h_ext;
	logic [9:0]    v_ext;
	logic          hsync;
	logic          vsync;

	// pixel enable, one system clock out of CE_DIV
	always_ff @(posedge CLOCK_48) begin
		if (rst) begin
			ce_cnt   <= '0;
			pixel_ce <= 1'b0;
		end else begin
			if (ce_cnt == CW'(CE_DIV - 1)) begin
				ce_cnt <= '0;
			end else begin
				ce_cnt <= ce_cnt + 1'b1;
			end
			pixel_ce <= (ce_cnt == CW'(CE_DIV - 1));
		end
	end

	assign h_last = (raster.h == 9'(H_TOTAL - 1));
	assign v_last = (raster.v == 9'(V_TOTAL - 1));

	always_ff @(posedge CLOCK_48) begin
		if (rst) begin
			raster <= '0;
		end else if (pixel_ce) begin
			if (h_last) begin
				raster.h <= '0;
				raster.v <= v_last ? 9'd0 : raster.v + 1'b1;
			end else begin
				raster.h <= raster.h + 1'b1;
			end
		end
	end

	// sync windows move with the menu offsets
	assign h_ext    = {1'b0, raster.h};
	assign v_ext    = {1'b0, raster.v};
	assign hs_start = 10'(H_ACTIVE + 8) + {5'b0, status.hoffs};
	assign vs_start = 10'(V_ACTIVE + 2) + {7'b0, status.voffs};
	assign hsync    = (h_ext >= hs_start) && (h_ext < hs_start + 10'(SYNC_LEN));
	assign vsync    = (v_ext >= vs_start) && (v_ext < vs_start + 10'd3);
	assign hblank   = (raster.h >= 9'(H_ACTIVE));
	assign vblank   = (raster.v >= 9'(V_ACTIVE));

	// registered on the same pixel edge that moves the counters
	always_ff @(posedge CLOCK_48) begin
		if (rst) begin
			sync      <= '0;
			video_rgb <= '0;
		end else if (pixel_ce) begin
			sync.hs <= hsync;
			sync.vs <= vsync;
			sync.hb <= hblank;
			sync.vb <= vblank;
			video_rgb <= (hblank || vblank) ? '0 : core_rgb; // black outside active area
		end
	end

endmodule

`default_nettype wire

// ==== verilog/arcade_shell.sv ====
`default_nettype none

module arcade_shell #(
	parameter logic [24:0] GFX_BASE = 25'h10000,
	parameter int          H_ACTIVE = 256,
	parameter int          H_TOTAL  = 384,
	parameter int          V_ACTIVE = 224,
	parameter int          V_TOTAL  = 264,
	parameter int          CE_DIV   = 8,
	parameter int          SYNC_LEN = 32
) (
	input  wire                 CLOCK_48,
	input  wire                 rst,
	input  shell_pkg::status_t  status,
	input  wire                 menu_reset_button,
	input  wire                 key_strobe,
	input  wire                 key_pressed,
	input  wire           [7:0] key_code,
	input  wire           [7:0] joystick_0,
	input  wire           [7:0] joystick_1,
	input  wire                 ioctl_download,
	input  wire           [7:0] ioctl_index,
	input  wire                 ioctl_wr,
	input  wire          [24:0] ioctl_addr,
	input  wire           [7:0] ioctl_dout,
	input  video_pkg::rgb_t     core_rgb,
	output shell_pkg::rom_wr_t  rom_wr,
	output logic                rom_loaded,
	output logic                core_reset,
	output shell_pkg::ctrl_t    ctrl,
	output video_pkg::raster_t  raster,
	output logic                pixel_ce,
	output video_pkg::sync_t    sync,
	output video_pkg::rgb_t     video_rgb
);

	shell_pkg::buttons_t buttons;

	key_decoder u_key_decoder (
		.CLOCK_48    (CLOCK_48),
		.rst         (rst),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.buttons     (buttons)
	);

	rom_loader #(
		.GFX_BASE (GFX_BASE)
	) u_rom_loader (
		.CLOCK_48          (CLOCK_48),
		.rst               (rst),
		.ioctl_download    (ioctl_download),
		.ioctl_index       (ioctl_index),
		.ioctl_wr          (ioctl_wr),
		.ioctl_addr        (ioctl_addr),
		.ioctl_dout        (ioctl_dout),
		.status            (status),
		.menu_reset_button (menu_reset_button),
		.rom_wr            (rom_wr),
		.rom_loaded        (rom_loaded),
		.core_reset        (core_reset)
	);

	control_mapper u_control_mapper (
		.CLOCK_48   (CLOCK_48),
		.rst        (rst),
		.buttons    (buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.ctrl       (ctrl)
	);

	video_timing #(
		.H_ACTIVE (H_ACTIVE),
		.H_TOTAL  (H_TOTAL),
		.V_ACTIVE (V_ACTIVE),
		.V_TOTAL  (V_TOTAL),
		.CE_DIV   (CE_DIV),
		.SYNC_LEN (SYNC_LEN)
	) u_video_timing (
		.CLOCK_48  (CLOCK_48),
		.rst       (rst),
		.status    (status),
		.core_rgb  (core_rgb),
		.pixel_ce  (pixel_ce),
		.raster    (raster),
		.sync      (sync),
		.video_rgb (video_rgb)
	);

endmodule

`default_nettype wire

// ==== testbench/arcade_shell_assert.sv ====
`default_nettype none

module arcade_shell_assert #(
	parameter int CE_DIV = 1
) (
	input wire        CLOCK_48,
	input wire        rst,
	input wire        cpu_req,
	input wire        gfx_req,
	input wire        pixel_ce,
	input wire        blank,
	input wire [11:0] video_rgb
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// one request toggle per accepted byte
	single_toggle: assert property (@(posedge CLOCK_48) disable iff (rst)
		!((cpu_req != $past(cpu_req)) && (gfx_req != $past(gfx_req))))
		else begin
			$error("cpu and gfx request toggles flipped in the same cycle");
			fail_count++;
		end

	ce_single: assert property (@(posedge CLOCK_48) disable iff (rst)
		(CE_DIV > 1 && pixel_ce) |=> !pixel_ce)
		else begin
			$error("pixel_ce high on two consecutive cycles");
			fail_count++;
		end

	black_in_blank: assert property (@(posedge CLOCK_48) disable iff (rst)
		blank |-> (video_rgb == 12'd0))
		else begin
			$error("video_rgb not black during blanking");
			fail_count++;
		end

endmodule

bind rom_loader arcade_shell_assert u_assert (
	.CLOCK_48  (CLOCK_48),
	.rst       (rst),
	.cpu_req   (rom_wr.cpu_req),
	.gfx_req   (rom_wr.gfx_req),
	.pixel_ce  (1'b0),
	.blank     (1'b0),
	.video_rgb (12'd0)
);

bind video_timing arcade_shell_assert #(.CE_DIV(CE_DIV)) u_assert (
	.CLOCK_48  (CLOCK_48),
	.rst       (rst),
	.cpu_req   (1'b0),
	.gfx_req   (1'b0),
	.pixel_ce  (pixel_ce),
	.blank     (sync.hb | sync.vb),
	.video_rgb (video_rgb)
);

`default_nettype wire

// ==== testbench/arcade_shell_tb.sv ====
`default_nettype none

module arcade_shell_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int H_ACTIVE = 16;
	localparam int H_TOTAL = 24;
	localparam int V_ACTIVE = 6;
	localparam int V_TOTAL = 12;
	localparam int CE_DIV = 2;
	localparam int SYNC_LEN = 3;
	localparam logic [24:0] GFX_BASE = 25'h10000;
	localparam int N_KEYS = 60;
	localparam int N_WRITES = 40;
	localparam int N_OFFSETS = 4;
	localparam int FRAME = H_TOTAL * V_TOTAL * CE_DIV; // system clocks per frame
	localparam int TIMEOUT = 2 * (2 * N_KEYS + 3 * N_WRITES + 20 + (2 + N_OFFSETS) * FRAME);
	localparam logic [7:0] KEY_TABLE [9] = '{shell_pkg::KEY_UP, shell_pkg::KEY_DOWN,
		shell_pkg::KEY_LEFT, shell_pkg::KEY_RIGHT, shell_pkg::KEY_ESC, shell_pkg::KEY_F1,
		shell_pkg::KEY_F2, shell_pkg::KEY_ALT, shell_pkg::KEY_SPACE};

	logic CLOCK_48 = 1'b0;
	logic rst;
	shell_pkg::status_t status;
	logic menu_reset_button, key_strobe, key_pressed, ioctl_download, ioctl_wr;
	logic [7:0] key_code, joystick_0, joystick_1, ioctl_index, ioctl_dout;
	logic [24:0] ioctl_addr;
	video_pkg::rgb_t core_rgb, video_rgb, prev_rgb, exp_rgb;
	shell_pkg::rom_wr_t rom_wr;
	logic rom_loaded, core_reset, pixel_ce, prev_ce, ce_seen;
	shell_pkg::ctrl_t ctrl;
	video_pkg::raster_t raster;
	video_pkg::sync_t sync, exp_sync;
	shell_pkg::status_t prev_status;
	shell_pkg::buttons_t btn; // model of the held buttons
	string test_name;
	int checks, errors, test_errors, cycle_count, ref_h, ref_v, ce_gap, hs0, vs0;
	int visits [0:H_TOTAL-1][0:V_TOTAL-1];

	arcade_shell #(.GFX_BASE(GFX_BASE), .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
		.V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL), .CE_DIV(CE_DIV), .SYNC_LEN(SYNC_LEN)) dut (.*);

	always #5 CLOCK_48 = ~CLOCK_48;

	task automatic step(input int n = 1);
		repeat (n) @(posedge CLOCK_48);
		#1;
	endtask

	task automatic compare(input string what, input logic [47:0] exp, input logic [47:0] act);
		checks++;
		assert (act === exp) else begin
			$display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = errors;
	endtask

	task automatic finish_test();
		$display("test %-14s %s, %0d errors", test_name,
			(errors == test_errors) ? "ok" : "failed", errors - test_errors);
	endtask

	function automatic shell_pkg::buttons_t press(input shell_pkg::buttons_t b,
			input logic [7:0] code, input logic lvl);
		case (code)
			shell_pkg::KEY_UP: b.up = lvl;
			shell_pkg::KEY_DOWN: b.down = lvl;
			shell_pkg::KEY_LEFT: b.left = lvl;
			shell_pkg::KEY_RIGHT: b.right = lvl;
			shell_pkg::KEY_ESC: b.coin = lvl;
			shell_pkg::KEY_F1: b.one_player = lvl;
			shell_pkg::KEY_F2: b.two_players = lvl;
			shell_pkg::KEY_ALT: b.fire2 = lvl;
			shell_pkg::KEY_SPACE: b.fire1 = lvl;
			default: ; // unknown codes change nothing
		endcase
		return b;
	endfunction

	function automatic shell_pkg::ctrl_t expected_ctrl(input shell_pkg::buttons_t b,
			input logic [7:0] j0, input logic [7:0] j1, input shell_pkg::status_t st);
		logic [7:0] j;
		logic l, r, f;
		shell_pkg::ctrl_t c;
		j = j0 | j1;
		l = st.rotate ? (b.down | j[2]) : (b.left | j[1]);
		r = st.rotate ? (b.up | j[3]) : (b.right | j[0]);
		f = b.fire1 | j[4];
		c.ctr1 = ~{1'b0, st.service, b.one_player, 2'b00, f, r, l};
		c.ctr2 = ~{~b.coin, 1'b0, b.two_players, 2'b00, f, r, l};
		return c;
	endfunction

	task automatic run_keys();
		int idx;
		begin_test("key_mapping");
		for (int i = 0; i < N_KEYS; i++) begin
			idx = $urandom_range(11, 0);
			key_code = (idx < 9) ? KEY_TABLE[idx] : 8'($urandom);
			key_pressed = $urandom_range(1, 0);
			key_strobe = 1'b1;
			joystick_0 = ($urandom_range(3, 0) == 0) ? 8'($urandom) : 8'h00;
			joystick_1 = ($urandom_range(3, 0) == 0) ? 8'($urandom) : 8'h00;
			status.rotate = (i >= N_KEYS / 2);
			status.service = $urandom_range(1, 0);
			btn = press(btn, key_code, key_pressed);
			step();
			key_strobe = 1'b0;
			step(); // strobe to ctrl is two clocks
			compare("ctrl", expected_ctrl(btn, joystick_0, joystick_1, status), ctrl);
		end
		finish_test();
	endtask

	task automatic run_download();
		shell_pkg::rom_wr_t exp;
		logic [24:0] rel;
		begin_test("download");
		exp = '0;
		ioctl_download = 1'b1;
		for (int i = 0; i < N_WRITES; i++) begin
			ioctl_addr = 25'($urandom_range(32'h1FFFF, 0)); // both regions
			ioctl_dout = 8'($urandom);
			ioctl_index = 8'($urandom_range(3, 0));
			ioctl_wr = 1'b1;
			if (ioctl_addr < GFX_BASE) begin
				exp.cpu_req = ~exp.cpu_req;
				rel = ioctl_addr;
			end else begin
				exp.gfx_req = ~exp.gfx_req;
				rel = ioctl_addr - GFX_BASE;
			end
			exp.addr = rel[23:1];
			exp.ds = ioctl_addr[0] ? 2'b10 : 2'b01;
			exp.data = {ioctl_dout, ioctl_dout};
			exp.index = ioctl_index[1:0];
			step();
			compare("rom_wr", exp, rom_wr);
			compare("core_reset during download", 1'b1, core_reset);
			if ($urandom_range(1, 0)) step(); // long strobe, still one flip
			ioctl_wr = 1'b0;
			step();
			compare("rom_wr held", exp, rom_wr);
		end
		finish_test();
	endtask

	task automatic run_reset_release();
		begin_test("reset_release");
		ioctl_download = 1'b0;
		step();
		compare("rom_loaded", 1'b1, rom_loaded);
		compare("core_reset one cycle after end", 1'b1, core_reset);
		step();
		compare("core_reset released", 1'b0, core_reset);
		status.reset_req = 1'b1;
		step();
		compare("core_reset on status reset", 1'b1, core_reset);
		status.reset_req = 1'b0;
		step();
		compare("core_reset after status reset", 1'b0, core_reset);
		menu_reset_button = 1'b1;
		step();
		compare("core_reset on menu button", 1'b1, core_reset);
		menu_reset_button = 1'b0;
		step();
		compare("core_reset after menu button", 1'b0, core_reset);
		finish_test();
	endtask

	task automatic run_raster();
		begin_test("raster_sweep");
		core_rgb = 12'($urandom);
		foreach (visits[h, v]) visits[h][v] = 0;
		for (int n = 0; n < 2 * H_TOTAL * V_TOTAL; n++) begin
			do step(); while (!pixel_ce);
			visits[raster.h][raster.v]++;
		end
		foreach (visits[h, v]) compare($sformatf("visits %0d,%0d", h, v), 2, visits[h][v]);
		finish_test();
	endtask

	task automatic run_offsets();
		begin_test("offsets_rgb");
		for (int r = 0; r < N_OFFSETS; r++) begin
			status.hoffs = 5'($urandom);
			status.voffs = 3'($urandom);
			for (int c = 0; c < FRAME; c++) begin
				core_rgb = 12'($urandom);
				step();
			end
		end
		finish_test();
	endtask

	// reference raster, sync and colour, sampled mid cycle
	always @(negedge CLOCK_48) begin
		if (rst) begin
			ref_h = 0;
			ref_v = 0;
			prev_ce = 1'b0;
			ce_seen = 1'b0;
			ce_gap = 0;
			exp_sync = '0;
			exp_rgb = '0;
		end else begin
			if (prev_ce) begin
				hs0 = H_ACTIVE + 8 + prev_status.hoffs;
				vs0 = V_ACTIVE + 2 + prev_status.voffs;
				exp_sync.hs = (ref_h >= hs0) && (ref_h < hs0 + SYNC_LEN);
				exp_sync.vs = (ref_v >= vs0) && (ref_v < vs0 + 3);
				exp_sync.hb = (ref_h >= H_ACTIVE);
				exp_sync.vb = (ref_v >= V_ACTIVE);
				exp_rgb = (exp_sync.hb || exp_sync.vb) ? 12'd0 : prev_rgb;
				ref_h = (ref_h + 1) % H_TOTAL;
				if (ref_h == 0) ref_v = (ref_v + 1) % V_TOTAL;
			end
			compare("raster", {9'(ref_h), 9'(ref_v)}, raster);
			compare("sync", exp_sync, sync);
			compare("video_rgb", exp_rgb, video_rgb);
			ce_gap++;
			if (pixel_ce) begin
				if (ce_seen) compare("pixel_ce period", CE_DIV, ce_gap);
				ce_seen = 1'b1;
				ce_gap = 0;
			end
		end
		prev_ce = pixel_ce;
		prev_status = status;
		prev_rgb = core_rgb;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT) begin
			@(posedge CLOCK_48);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h80f7_fecb));
		rst = 1'b1;
		status = '0;
		menu_reset_button = 1'b0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = 8'h00;
		joystick_0 = 8'h00;
		joystick_1 = 8'h00;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = 8'h00;
		core_rgb = '0;
		btn = '0;
		checks = 0;
		errors = 0;
		step(2);
		rst = 1'b0;
		begin_test("reset_state");
		compare("ctrl", expected_ctrl('0, 8'h00, 8'h00, status), ctrl);
		compare("request toggles", 2'b00, {rom_wr.cpu_req, rom_wr.gfx_req});
		compare("rom_loaded", 1'b0, rom_loaded);
		compare("core_reset", 1'b1, core_reset);
		finish_test();
		run_keys();
		run_download();
		run_reset_release();
		run_raster();
		run_offsets();
		begin_test("assertions");
		errors += dut.u_rom_loader.u_assert.fail_count;
		errors += dut.u_video_timing.u_assert.fail_count;
		finish_test();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/shell_pkg.sv
verilog/video_pkg.sv
verilog/key_decoder.sv
verilog/rom_loader.sv
verilog/control_mapper.sv
verilog/video_timing.sv
verilog/arcade_shell.sv
testbench/arcade_shell_assert.sv
testbench/arcade_shell_tb.sv
